//--- common/bin_params.svh
`ifndef BIN_PARAMS_SVH
`define BIN_PARAMS_SVH

// clauses, variables and levels per bin
`define NUM_SLOTS 8

// variable index and decision level
`define WIDTH_VAR 12
`define WIDTH_LVL 16

`define WIDTH_BIN_ID 10

// variable-state and level-state words
`define WIDTH_STATE 30

// all bin memories share this depth
`define ADDR_W 9

// two literal bits per variable slot
`define WIDTH_CLAUSE (2 * `NUM_SLOTS)

`endif

//--- common/sat_state_pkg.sv
`include "bin_params.svh"

package sat_state_pkg;

    // literal pair per variable slot
    typedef logic [`WIDTH_CLAUSE-1:0] clause_t;

    typedef logic [`WIDTH_STATE-1:0] var_state_t;

    typedef logic [`WIDTH_STATE-1:0] lvl_state_t;

    // one bin's worth of state words, slot 0 in the low bits
    typedef var_state_t [`NUM_SLOTS-1:0] var_state_arr_t;

    typedef lvl_state_t [`NUM_SLOTS-1:0] lvl_state_arr_t;

endpackage

//--- common/bin_addr_pkg.sv
`include "bin_params.svh"

package bin_addr_pkg;

    typedef logic [`WIDTH_BIN_ID-1:0] bin_id_t;

    typedef logic [`WIDTH_LVL-1:0] lvl_t;

    // address of any bin memory
    typedef logic [`ADDR_W-1:0] ram_addr_t;

    typedef logic [`WIDTH_VAR-1:0] var_idx_t;

    // one-hot slot select
    typedef logic [`NUM_SLOTS-1:0] slot_mask_t;

endpackage

//--- hw/bin_ram.sv
`timescale 1ns/1ps

`include "bin_params.svh"

module bin_ram #(
    parameter int DATA_W = `WIDTH_STATE,
    parameter int ADDR_W = `ADDR_W
) (
    input  logic                     clk,

    input  logic                     we_i,
    input  bin_addr_pkg::ram_addr_t  waddr_i,
    input  logic [DATA_W-1:0]        wdata_i,

    input  bin_addr_pkg::ram_addr_t  raddr_i,
    output logic [DATA_W-1:0]        rdata_o
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // read sees the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- update_bin/update_bin.sv
`timescale 1ns/1ps

`include "bin_params.svh"

module update_bin (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          start_update_i,
    input  bin_addr_pkg::bin_id_t         cur_bin_num_i,
    output logic                          apply_update_o,
    output logic                          done_update_o,

    // clause array of the engine
    output bin_addr_pkg::slot_mask_t      rd_carray_o,
    input  sat_state_pkg::clause_t        clause_i,

    input  sat_state_pkg::var_state_arr_t var_state_i,
    input  sat_state_pkg::lvl_state_arr_t lvl_states_i,
    input  bin_addr_pkg::lvl_t            base_lvl_i,

    // clause bin memory
    output logic                          c_we_o,
    output bin_addr_pkg::ram_addr_t       c_addr_o,
    output sat_state_pkg::clause_t        c_data_o,

    // variable bin memory, read side
    output bin_addr_pkg::ram_addr_t       v_addr_o,
    input  bin_addr_pkg::var_idx_t        var_idx_i,

    // variable-state memory
    output logic                          vs_we_o,
    output bin_addr_pkg::ram_addr_t       vs_addr_o,
    output sat_state_pkg::var_state_t     vs_data_o,

    // level-state memory
    output logic                          ls_we_o,
    output bin_addr_pkg::ram_addr_t       ls_addr_o,
    output sat_state_pkg::lvl_state_t     ls_data_o
);

    import sat_state_pkg::*;
    import bin_addr_pkg::*;

    localparam int unsigned CNT_W = $clog2(`NUM_SLOTS);
    localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`NUM_SLOTS - 1);

    typedef enum logic [1:0] {
        IDLE,
        UPDATE,
        DONE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] slot_cnt;

    slot_mask_t       ls_sel;
    slot_mask_t       vs_sel;
    logic [2:0]       done_sr;

    ram_addr_t        bin_base;
    ram_addr_t        lvl_base;
    ram_addr_t        slot_addr;

    var_state_t       vs_word;
    lvl_state_t       ls_word;

    // AND-OR pick of the word under a one-hot mask
    function automatic logic [`WIDTH_STATE-1:0] pick_slot(
        input logic [`NUM_SLOTS-1:0][`WIDTH_STATE-1:0] words,
        input slot_mask_t                              mask
    );
        logic [`WIDTH_STATE-1:0] acc;
        acc = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            acc |= words[i] & {`WIDTH_STATE{mask[i]}};
        end
        return acc;
    endfunction

    // bins start at address 1, clause and variable regions alike
    assign bin_base = ram_addr_t'((cur_bin_num_i - 1'b1) * `NUM_SLOTS + 1);
    assign lvl_base = ram_addr_t'(base_lvl_i);

    assign vs_word = pick_slot(var_state_i, vs_sel);
    assign ls_word = pick_slot(lvl_states_i, ls_sel);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= IDLE;
            slot_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    slot_cnt <= '0;
                    if (start_update_i) begin
                        state <= UPDATE;
                    end
                end
                UPDATE: begin
                    slot_cnt <= slot_cnt + 1'b1;
                    if (slot_cnt == LAST_SLOT) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    slot_cnt <= '0;
                    // drop to idle as done goes out
                    if (done_sr[1]) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // clause strobe first, level and variable strobes trail by one and two
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_carray_o <= '0;
            ls_sel      <= '0;
            vs_sel      <= '0;
        end else begin
            if (|rd_carray_o) begin
                rd_carray_o <= rd_carray_o << 1;
            end else if (state == UPDATE && slot_cnt == '0) begin
                rd_carray_o <= slot_mask_t'(1);
            end else begin
                rd_carray_o <= '0;
            end
            ls_sel <= rd_carray_o;
            vs_sel <= ls_sel;
        end
    end

    // clause address doubles as the variable bin read address
    always_ff @(posedge clk) begin
        if (rd_carray_o[0]) begin
            slot_addr <= bin_base;
        end else if (|rd_carray_o) begin
            slot_addr <= slot_addr + 1'b1;
        end
        c_data_o <= clause_i;
    end

    assign c_addr_o = slot_addr;
    assign v_addr_o = slot_addr;

    always_ff @(posedge clk) begin
        if (ls_sel[0]) begin
            ls_addr_o <= lvl_base;
        end else if (|ls_sel) begin
            ls_addr_o <= ls_addr_o + 1'b1;
        end
        ls_data_o <= ls_word;
    end

    // variable index comes back from the bin memory one cycle after v_addr_o
    always_ff @(posedge clk) begin
        vs_addr_o <= ram_addr_t'(var_idx_i);
        vs_data_o <= vs_word;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            c_we_o  <= 1'b0;
            ls_we_o <= 1'b0;
            vs_we_o <= 1'b0;
        end else begin
            c_we_o  <= |rd_carray_o;
            ls_we_o <= |ls_sel;
            vs_we_o <= |vs_sel;
        end
    end

    // done trails the last variable-state write by two cycles
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_sr        <= '0;
            apply_update_o <= 1'b0;
        end else begin
            done_sr        <= {done_sr[1:0], vs_sel[`NUM_SLOTS-1]};
            apply_update_o <= (state != IDLE) && !done_sr[1];
        end
    end

    assign done_update_o = done_sr[2];

endmodule

//--- hw/bin_update_top.sv
`timescale 1ns/1ps

module bin_update_top (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          start_update_i,
    input  bin_addr_pkg::bin_id_t         cur_bin_num_i,
    input  sat_state_pkg::clause_t        clause_i,
    input  sat_state_pkg::var_state_arr_t var_state_i,
    input  sat_state_pkg::lvl_state_arr_t lvl_states_i,
    input  bin_addr_pkg::lvl_t            base_lvl_i,
    output logic                          apply_update_o,
    output logic                          done_update_o,
    output bin_addr_pkg::slot_mask_t      rd_carray_o,

    // host preload of variable indices
    input  logic                          vbin_we_i,
    input  bin_addr_pkg::ram_addr_t       vbin_addr_i,
    input  bin_addr_pkg::var_idx_t        vbin_data_i,

    // host readback
    input  bin_addr_pkg::ram_addr_t       c_raddr_i,
    output sat_state_pkg::clause_t        c_rdata_o,
    input  bin_addr_pkg::ram_addr_t       vs_raddr_i,
    output sat_state_pkg::var_state_t     vs_rdata_o,
    input  bin_addr_pkg::ram_addr_t       ls_raddr_i,
    output sat_state_pkg::lvl_state_t     ls_rdata_o
);

    import sat_state_pkg::*;
    import bin_addr_pkg::*;

    logic       c_we;
    ram_addr_t  c_addr;
    clause_t    c_data;

    ram_addr_t  v_addr;
    var_idx_t   var_idx;

    logic       vs_we;
    ram_addr_t  vs_addr;
    var_state_t vs_data;

    logic       ls_we;
    ram_addr_t  ls_addr;
    lvl_state_t ls_data;

    update_bin i_update_bin (
        .clk            (clk),
        .rst            (rst),
        .start_update_i (start_update_i),
        .cur_bin_num_i  (cur_bin_num_i),
        .apply_update_o (apply_update_o),
        .done_update_o  (done_update_o),
        .rd_carray_o    (rd_carray_o),
        .clause_i       (clause_i),
        .var_state_i    (var_state_i),
        .lvl_states_i   (lvl_states_i),
        .base_lvl_i     (base_lvl_i),
        .c_we_o         (c_we),
        .c_addr_o       (c_addr),
        .c_data_o       (c_data),
        .v_addr_o       (v_addr),
        .var_idx_i      (var_idx),
        .vs_we_o        (vs_we),
        .vs_addr_o      (vs_addr),
        .vs_data_o      (vs_data),
        .ls_we_o        (ls_we),
        .ls_addr_o      (ls_addr),
        .ls_data_o      (ls_data)
    );

    bin_ram #(
        .DATA_W ($bits(clause_t)),
        .ADDR_W ($bits(ram_addr_t))
    ) i_clause_ram (
        .clk     (clk),
        .we_i    (c_we),
        .waddr_i (c_addr),
        .wdata_i (c_data),
        .raddr_i (c_raddr_i),
        .rdata_o (c_rdata_o)
    );

    // written by the host, read by the controller
    bin_ram #(
        .DATA_W ($bits(var_idx_t)),
        .ADDR_W ($bits(ram_addr_t))
    ) i_vbin_ram (
        .clk     (clk),
        .we_i    (vbin_we_i),
        .waddr_i (vbin_addr_i),
        .wdata_i (vbin_data_i),
        .raddr_i (v_addr),
        .rdata_o (var_idx)
    );

    bin_ram #(
        .DATA_W ($bits(var_state_t)),
        .ADDR_W ($bits(ram_addr_t))
    ) i_vstate_ram (
        .clk     (clk),
        .we_i    (vs_we),
        .waddr_i (vs_addr),
        .wdata_i (vs_data),
        .raddr_i (vs_raddr_i),
        .rdata_o (vs_rdata_o)
    );

    bin_ram #(
        .DATA_W ($bits(lvl_state_t)),
        .ADDR_W ($bits(ram_addr_t))
    ) i_lstate_ram (
        .clk     (clk),
        .we_i    (ls_we),
        .waddr_i (ls_addr),
        .wdata_i (ls_data),
        .raddr_i (ls_raddr_i),
        .rdata_o (ls_rdata_o)
    );

endmodule

//--- tests/tb_bin_update.sv
`timescale 1ns/1ps

`include "bin_params.svh"

module tb_bin_update;

    import sat_state_pkg::*;
    import bin_addr_pkg::*;

    localparam int NUM_UPDATES = 16;
    localparam int CYCLE_LIMIT = 40 * NUM_UPDATES + 200;
    localparam int MEM_DEPTH   = 2 ** `ADDR_W;
    localparam int B2B_RUNS    = 12;

    logic           clk = 1'b0;
    logic           rst;
    logic           start_update_i;
    bin_id_t        cur_bin_num_i;
    clause_t        clause_i;
    var_state_arr_t var_state_i;
    lvl_state_arr_t lvl_states_i;
    lvl_t           base_lvl_i;
    logic           apply_update_o;
    logic           done_update_o;
    slot_mask_t     rd_carray_o;
    logic           vbin_we_i;
    ram_addr_t      vbin_addr_i;
    var_idx_t       vbin_data_i;
    ram_addr_t      c_raddr_i;
    clause_t        c_rdata_o;
    ram_addr_t      vs_raddr_i;
    var_state_t     vs_rdata_o;
    ram_addr_t      ls_raddr_i;
    lvl_state_t     ls_rdata_o;

    // shadow memories
    clause_t    shadow_c    [MEM_DEPTH];
    var_idx_t   shadow_vbin [MEM_DEPTH];
    var_state_t shadow_vs   [MEM_DEPTH];
    lvl_state_t shadow_ls   [MEM_DEPTH];

    // addresses waiting for readback
    ram_addr_t rb_c  [$];
    ram_addr_t rb_vs [$];
    ram_addr_t rb_ls [$];

    integer seed;
    int     errors;
    int     checks;
    int     cycle_cnt;
    event   readback_go;
    event   readback_done;

    bin_id_t                  cur_bin;
    lvl_t                     cur_base;
    var_state_arr_t           cur_vs;
    lvl_state_arr_t           cur_ls;
    clause_t [`NUM_SLOTS-1:0] cur_clauses;
    var_idx_t                 cur_idx  [`NUM_SLOTS];
    var_idx_t                 prev_idx [`NUM_SLOTS];
    logic                     avoid_addr [MEM_DEPTH];

    bin_id_t                  b2b_bin  [B2B_RUNS];
    lvl_t                     b2b_base [B2B_RUNS];
    var_state_arr_t           b2b_vs   [B2B_RUNS];
    lvl_state_arr_t           b2b_ls   [B2B_RUNS];
    clause_t [`NUM_SLOTS-1:0] b2b_cl   [B2B_RUNS];

    bin_update_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .start_update_i (start_update_i),
        .cur_bin_num_i  (cur_bin_num_i),
        .clause_i       (clause_i),
        .var_state_i    (var_state_i),
        .lvl_states_i   (lvl_states_i),
        .base_lvl_i     (base_lvl_i),
        .apply_update_o (apply_update_o),
        .done_update_o  (done_update_o),
        .rd_carray_o    (rd_carray_o),
        .vbin_we_i      (vbin_we_i),
        .vbin_addr_i    (vbin_addr_i),
        .vbin_data_i    (vbin_data_i),
        .c_raddr_i      (c_raddr_i),
        .c_rdata_o      (c_rdata_o),
        .vs_raddr_i     (vs_raddr_i),
        .vs_rdata_o     (vs_rdata_o),
        .ls_raddr_i     (ls_raddr_i),
        .ls_rdata_o     (ls_rdata_o)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // bin regions of eight words start at address 1
    function automatic void expected_update(input bin_id_t bin,
                                            input clause_t [`NUM_SLOTS-1:0] clauses,
                                            input var_state_arr_t vs,
                                            input lvl_state_arr_t ls,
                                            input lvl_t base);
        int        bin_base;
        ram_addr_t a;
        ram_addr_t va;
        ram_addr_t la;
        bin_base = (int'(bin) - 1) * `NUM_SLOTS + 1;
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            a = ram_addr_t'(bin_base + k);
            shadow_c[a] = clauses[k];
            rb_c.push_back(a);
            va = ram_addr_t'(shadow_vbin[a]);
            shadow_vs[va] = vs[k];
            rb_vs.push_back(va);
            la = ram_addr_t'(int'(base) + k);
            shadow_ls[la] = ls[k];
            rb_ls.push_back(la);
        end
    endfunction

    function automatic clause_t slot_clause(input slot_mask_t strobe);
        clause_t c;
        c = '0;
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            if (strobe[k]) begin
                c = cur_clauses[k];
            end
        end
        return c;
    endfunction

    function automatic bin_id_t pick_bin();
        logic [31:0] r;
        r = $random(seed);
        return (r[9:0] == '0) ? bin_id_t'(1) : r[9:0];
    endfunction

    task automatic random_inputs();
        logic [31:0] r;
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            r = $random(seed);
            cur_clauses[k] = r[15:0];
            r = $random(seed);
            cur_vs[k] = r[29:0];
            r = $random(seed);
            cur_ls[k] = r[29:0];
        end
    endtask

    // distinct target addresses that avoid_addr leaves free
    task automatic pick_indices();
        logic        taken [MEM_DEPTH];
        logic [31:0] r;
        var_idx_t    v;
        int          k;
        foreach (taken[i]) taken[i] = avoid_addr[i];
        k = 0;
        while (k < `NUM_SLOTS) begin
            r = $random(seed);
            v = r[11:0];
            if (!taken[ram_addr_t'(v)]) begin
                taken[ram_addr_t'(v)] = 1'b1;
                cur_idx[k] = v;
                k++;
            end
        end
    endtask

    task automatic preload_vbin(input bin_id_t bin);
        int bin_base;
        bin_base = (int'(bin) - 1) * `NUM_SLOTS + 1;
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            vbin_we_i   = 1'b1;
            vbin_addr_i = ram_addr_t'(bin_base + k);
            vbin_data_i = cur_idx[k];
            shadow_vbin[ram_addr_t'(bin_base + k)] = cur_idx[k];
            step_cycle();
        end
        vbin_we_i = 1'b0;
    endtask

    task automatic run_update(input logic second_start);
        int   n;
        logic done_seen;
        cur_bin_num_i  = cur_bin;
        var_state_i    = cur_vs;
        lvl_states_i   = cur_ls;
        base_lvl_i     = cur_base;
        start_update_i = 1'b1;
        expected_update(cur_bin, cur_clauses, cur_vs, cur_ls, cur_base);
        step_cycle();
        start_update_i = 1'b0;
        check("apply_update_o", 32'd0, 32'(apply_update_o));
        n = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            step_cycle();
            n++;
            // a start while busy must be ignored
            start_update_i = second_start && (n == 4);
            check("apply_update_o", 32'(n >= 1 && n <= 12), 32'(apply_update_o));
            check("rd_carray_o", (n <= `NUM_SLOTS) ? (32'd1 << (n - 1)) : 32'd0,
                  32'(rd_carray_o));
            check("done_update_o", 32'(n == 13), 32'(done_update_o));
            done_seen = done_update_o;
        end
        check("start-to-done cycles", 32'd13, 32'(n));
    endtask

    task automatic request_readback();
        -> readback_go;
        @(readback_done);
    endtask

    // engine side of the clause array
    initial begin
        clause_i = '0;
        forever begin
            @(posedge clk);
            #1;
            clause_i = slot_clause(rd_carray_o);
        end
    end

    // readback and compare against the shadows
    initial begin
        int n;
        c_raddr_i  = '0;
        vs_raddr_i = '0;
        ls_raddr_i = '0;
        forever begin
            @(readback_go);
            n = rb_c.size();
            if (rb_vs.size() > n) n = rb_vs.size();
            if (rb_ls.size() > n) n = rb_ls.size();
            for (int i = 0; i < n; i++) begin
                if (i < rb_c.size()) c_raddr_i = rb_c[i];
                if (i < rb_vs.size()) vs_raddr_i = rb_vs[i];
                if (i < rb_ls.size()) ls_raddr_i = rb_ls[i];
                step_cycle();
                if (i < rb_c.size()) begin
                    check($sformatf("c_rdata_o[%03h]", rb_c[i]),
                          32'(shadow_c[rb_c[i]]), 32'(c_rdata_o));
                end
                if (i < rb_vs.size()) begin
                    check($sformatf("vs_rdata_o[%03h]", rb_vs[i]),
                          32'(shadow_vs[rb_vs[i]]), 32'(vs_rdata_o));
                end
                if (i < rb_ls.size()) begin
                    check($sformatf("ls_rdata_o[%03h]", rb_ls[i]),
                          32'(shadow_ls[rb_ls[i]]), 32'(ls_rdata_o));
                end
            end
            rb_c.delete();
            rb_vs.delete();
            rb_ls.delete();
            -> readback_done;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the updates never completed", cycle_cnt);
        $display("checks %0d errors %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        seed           = 32'h63ef8d4a;
        errors         = 0;
        checks         = 0;
        rst            = 1'b0;
        start_update_i = 1'b0;
        cur_bin_num_i  = bin_id_t'(1);
        var_state_i    = '0;
        lvl_states_i   = '0;
        base_lvl_i     = '0;
        vbin_we_i      = 1'b0;
        vbin_addr_i    = '0;
        vbin_data_i    = '0;
        cur_clauses    = '0;
        foreach (avoid_addr[i]) avoid_addr[i] = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        // quiet outputs out of reset
        repeat (3) begin
            step_cycle();
            check("apply_update_o", 32'd0, 32'(apply_update_o));
            check("done_update_o", 32'd0, 32'(done_update_o));
            check("rd_carray_o", 32'd0, 32'(rd_carray_o));
        end

        // clause region of a random bin
        cur_bin = pick_bin();
        r = $random(seed);
        cur_base = r[15:0];
        random_inputs();
        pick_indices();
        preload_vbin(cur_bin);
        run_update(1'b0);
        request_readback();
        prev_idx = cur_idx;
        foreach (prev_idx[k]) avoid_addr[ram_addr_t'(prev_idx[k])] = 1'b1;

        // earlier words survive a scatter to fresh indices
        cur_bin = pick_bin();
        r = $random(seed);
        cur_base = r[15:0];
        random_inputs();
        pick_indices();
        foreach (avoid_addr[i]) avoid_addr[i] = 1'b0;
        preload_vbin(cur_bin);
        run_update(1'b0);
        foreach (prev_idx[k]) rb_vs.push_back(ram_addr_t'(prev_idx[k]));
        request_readback();

        // level base wraps past the top of the address space
        cur_bin = pick_bin();
        r = $random(seed);
        cur_base = {r[15:9], 9'h1fb};
        random_inputs();
        pick_indices();
        preload_vbin(cur_bin);
        run_update(1'b0);
        request_readback();

        // second start while busy
        cur_bin = pick_bin();
        r = $random(seed);
        cur_base = r[15:0];
        random_inputs();
        pick_indices();
        preload_vbin(cur_bin);
        run_update(1'b1);
        random_inputs();
        var_state_i  = cur_vs;
        lvl_states_i = cur_ls;
        repeat (16) begin
            step_cycle();
            check("apply_update_o", 32'd0, 32'(apply_update_o));
            check("done_update_o", 32'd0, 32'(done_update_o));
            check("rd_carray_o", 32'd0, 32'(rd_carray_o));
        end
        request_readback();

        // all variable bins loaded before the back-to-back updates
        for (int j = 0; j < B2B_RUNS; j++) begin
            b2b_bin[j] = pick_bin();
            r = $random(seed);
            b2b_base[j] = r[15:0];
            random_inputs();
            b2b_vs[j] = cur_vs;
            b2b_ls[j] = cur_ls;
            b2b_cl[j] = cur_clauses;
            pick_indices();
            preload_vbin(b2b_bin[j]);
        end
        for (int j = 0; j < B2B_RUNS; j++) begin
            cur_bin     = b2b_bin[j];
            cur_base    = b2b_base[j];
            cur_vs      = b2b_vs[j];
            cur_ls      = b2b_ls[j];
            cur_clauses = b2b_cl[j];
            run_update(1'b0);
        end
        request_readback();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+common
common/sat_state_pkg.sv
common/bin_addr_pkg.sv
hw/bin_ram.sv
update_bin/update_bin.sv
hw/bin_update_top.sv
tests/tb_bin_update.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bin update testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_bin_update \
    -Mdir obj_dir -o tb_bin_update \
    && ./obj_dir/tb_bin_update > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
